// File: hdl/exu_settings.svh
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// datapath widths
`define EXU_XLEN 32
`define EXU_REGW 5
`define EXU_CSRW 12

// machine-mode CSR numbers touched by ecall
`define EXU_CSR_MEPC   12'h341
`define EXU_CSR_MCAUSE 12'h342

// mcause code for an environment call from M mode
`define EXU_CAUSE_ECALL 11

`endif

// File: hdl/exu_pkg.sv
`include "exu_settings.svh"

package exu_pkg;

  typedef logic [`EXU_XLEN-1:0] word_t;
  typedef logic [`EXU_REGW-1:0] reg_addr_t;
  typedef logic [`EXU_CSRW-1:0] csr_addr_t;
  typedef logic [2:0]           funct_t;

  // major opcodes match inst[6:2]
  typedef enum logic [4:0] {
    op_load   = 5'b00000,
    op_calri  = 5'b00100,
    op_auipc  = 5'b00101,
    op_store  = 5'b01000,
    op_calrr  = 5'b01100,
    op_lui    = 5'b01101,
    op_branch = 5'b11000,
    op_jalr   = 5'b11001,
    op_jal    = 5'b11011,
    op_sys    = 5'b11100
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add  = 3'b000, // add or sub
    alu_sll  = 3'b001,
    alu_slt  = 3'b010,
    alu_sltu = 3'b011,
    alu_xor  = 3'b100,
    alu_srl  = 3'b101, // srl or sra
    alu_or   = 3'b110,
    alu_and  = 3'b111
  } alu_funct_e;

  typedef enum logic [2:0] {
    st_idle,
    st_load_req,
    st_load_wait,
    st_store_req,
    st_store_wait
  } exu_state_e;

  // one decoded instruction from the decoder
  typedef struct packed {
    word_t      pc;
    word_t      src1;
    word_t      src2;
    word_t      imm;
    word_t      csr_val;  // old value of the addressed CSR
    word_t      alu_a;
    word_t      alu_b;
    opcode_e    opcode;
    funct_t     funct;
    reg_addr_t  rd;
    alu_funct_e alu_funct;
    logic       alu_sub_sra;
  } exu_op_t;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } gpr_wr_t;

  typedef struct packed {
    logic      en;
    csr_addr_t addr;
    word_t     data;
  } csr_wr_t;

  typedef struct packed {
    word_t  addr;
    word_t  data;
    funct_t func; // access size and sign
  } mem_req_t;

endpackage

// File: hdl/exu_alu.sv
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_alu (
  input  exu_pkg::word_t      alu_a,
  input  exu_pkg::word_t      alu_b,
  input  exu_pkg::alu_funct_e alu_funct,
  input  logic                alu_sub_sra,
  output exu_pkg::word_t      alu_val
);
  import exu_pkg::*;

  localparam int shw = $clog2(`EXU_XLEN);

  logic [shw-1:0] shamt;
  word_t          sum;
  word_t          sra_val;
  logic           lt_s;
  logic           lt_u;

  assign shamt = alu_b[shw-1:0];

  // sub folds into the adder via two's complement
  assign sum = alu_sub_sra ? (alu_a - alu_b) : (alu_a + alu_b);

  assign sra_val = word_t'($signed(alu_a) >>> shamt);

  assign lt_s = $signed(alu_a) < $signed(alu_b);
  assign lt_u = alu_a < alu_b;

  always_comb begin
    case (alu_funct)
      alu_add:  alu_val = sum;
      alu_sll:  alu_val = alu_a << shamt;
      alu_slt:  alu_val = word_t'(lt_s);   // flag in bit 0
      alu_sltu: alu_val = word_t'(lt_u);
      alu_xor:  alu_val = alu_a ^ alu_b;
      alu_srl:  alu_val = alu_sub_sra ? sra_val : (alu_a >> shamt);
      alu_or:   alu_val = alu_a | alu_b;
      alu_and:  alu_val = alu_a & alu_b;
      default:  alu_val = sum;
    endcase
  end

endmodule

// File: hdl/exu_branch.sv
`timescale 1ns/1ps

module exu_branch (
  input  exu_pkg::exu_op_t op,
  input  exu_pkg::word_t   alu_val,
  output exu_pkg::word_t   npc
);
  import exu_pkg::*;

  // branch conditions in funct
  localparam funct_t br_beq  = 3'b000;
  localparam funct_t br_bne  = 3'b001;
  localparam funct_t br_blt  = 3'b100;
  localparam funct_t br_bge  = 3'b101;
  localparam funct_t br_bltu = 3'b110;
  localparam funct_t br_bgeu = 3'b111;

  logic  br_taken;  // only meaningful for op_branch
  logic  sys_jump;  // ecall or mret
  word_t base;
  word_t inc;
  word_t sum;

  always_comb begin
    case (op.funct)
      br_beq:          br_taken = ~|alu_val;  // alu did a-b
      br_bne:          br_taken = |alu_val;
      br_blt, br_bltu: br_taken = alu_val[0];
      br_bge, br_bgeu: br_taken = ~alu_val[0];
      default:         br_taken = 1'b0;
    endcase
  end

  assign sys_jump = (op.opcode == op_sys) && (op.funct == '0);

  always_comb begin
    if (op.opcode == op_jalr) base = op.src1;
    else if (sys_jump)        base = op.csr_val; // mtvec or mepc
    else                      base = op.pc;
  end

  always_comb begin
    case (op.opcode)
      op_jal, op_jalr: inc = op.imm;
      op_branch:       inc = br_taken ? op.imm : word_t'(4);
      op_sys:          inc = sys_jump ? '0 : word_t'(4);
      default:         inc = word_t'(4);
    endcase
  end

  assign sum = base + inc;
  assign npc = sum & ~word_t'(1);

endmodule

// File: hdl/exu_sys.sv
`timescale 1ns/1ps
`include "exu_settings.svh"

module exu_sys (
  input  exu_pkg::exu_op_t op,
  input  exu_pkg::word_t   alu_val,
  output exu_pkg::gpr_wr_t gpr_next,
  output exu_pkg::csr_wr_t csr1_next,
  output exu_pkg::csr_wr_t csr2_next
);
  import exu_pkg::*;

  csr_addr_t csr_addr;
  logic      csr_op;  // csrrw/csrrs/csrrc and immediate forms
  logic      ecall;

  assign csr_addr = op.imm[`EXU_CSRW-1:0];
  assign csr_op   = (op.opcode == op_sys) && (op.funct != '0);
  // mret shares funct 0 but carries a nonzero imm
  assign ecall    = (op.opcode == op_sys) && (op.funct == '0) && (csr_addr == '0);

  always_comb begin
    gpr_next.addr = op.rd;
    gpr_next.data = alu_val; // for load/store this is the memory address
    case (op.opcode)
      op_lui, op_auipc, op_jal, op_jalr,
      op_calri, op_calrr: gpr_next.en = 1'b1;
      op_sys: begin
        gpr_next.en   = csr_op;
        gpr_next.data = op.csr_val; // old csr value to rd
      end
      default:            gpr_next.en = 1'b0;
    endcase
  end

  // port 1 writes the csr op target or mepc on ecall
  assign csr1_next.en   = csr_op | ecall;
  assign csr1_next.addr = csr_op ? csr_addr : csr_addr_t'(`EXU_CSR_MEPC);
  assign csr1_next.data = alu_val; // pc on ecall

  // port 2 only carries the trap cause
  assign csr2_next.en   = ecall;
  assign csr2_next.addr = csr_addr_t'(`EXU_CSR_MCAUSE);
  assign csr2_next.data = word_t'(`EXU_CAUSE_ECALL);

endmodule

// File: hdl/exu_ctrl.sv
`timescale 1ns/1ps

module exu_ctrl (
  input  logic              clk,
  input  logic              rstn,
  input  exu_pkg::exu_op_t  op_in,
  input  logic              op_valid,
  output logic              op_ready,
  input  exu_pkg::gpr_wr_t  gpr_next,
  input  exu_pkg::csr_wr_t  csr1_next,
  input  exu_pkg::csr_wr_t  csr2_next,
  output exu_pkg::mem_req_t rreq,
  output logic              rreq_valid,
  input  logic              rreq_ready,
  input  exu_pkg::word_t    rdata,
  input  logic              rres_valid,
  output logic              rres_ready,
  output exu_pkg::mem_req_t wreq,
  output logic              wreq_valid,
  input  logic              wreq_ready,
  input  logic              wres_valid,
  output logic              wres_ready,
  output exu_pkg::gpr_wr_t  gpr_wr,
  output exu_pkg::csr_wr_t  csr_wr1,
  output exu_pkg::csr_wr_t  csr_wr2
);
  import exu_pkg::*;

  exu_state_e state;
  reg_addr_t  rd_q;     // load destination
  mem_req_t   mem_req;
  logic       op_hs;
  logic       rres_hs;
  logic       wres_hs;

  assign op_hs   = op_valid & op_ready;
  assign rres_hs = rres_valid & rres_ready;
  assign wres_hs = wres_valid & wres_ready;

  // gpr_next.data holds the alu sum of base and offset
  assign mem_req = '{addr: gpr_next.data, data: op_in.src2, func: op_in.funct};

  always_ff @(posedge clk) begin
    if (rstn) begin
      state      <= st_idle;
      op_ready   <= 1'b1;
      rreq_valid <= 1'b0;
      rres_ready <= 1'b0;
      wreq_valid <= 1'b0;
      wres_ready <= 1'b0;
      gpr_wr.en  <= 1'b0;
      csr_wr1.en <= 1'b0;
      csr_wr2.en <= 1'b0;
    end else begin
      // write enables are single-cycle pulses
      gpr_wr.en  <= 1'b0;
      csr_wr1.en <= 1'b0;
      csr_wr2.en <= 1'b0;
      case (state)
        st_idle: begin
          if (op_hs) begin
            gpr_wr  <= gpr_next; // en is low for load/store
            csr_wr1 <= csr1_next;
            csr_wr2 <= csr2_next;
            rd_q    <= op_in.rd;
            if (op_in.opcode == op_load) begin
              rreq       <= mem_req;
              rreq_valid <= 1'b1;
              rres_ready <= 1'b1;
              op_ready   <= 1'b0;
              state      <= st_load_req;
            end else if (op_in.opcode == op_store) begin
              wreq       <= mem_req;
              wreq_valid <= 1'b1;
              wres_ready <= 1'b1;
              op_ready   <= 1'b0;
              state      <= st_store_req;
            end
          end
        end
        st_load_req, st_load_wait: begin
          if (rreq_valid && rreq_ready) begin
            rreq_valid <= 1'b0;
            state      <= st_load_wait;
          end
          if (rres_hs) begin
            rres_ready  <= 1'b0;
            gpr_wr.en   <= 1'b1;
            gpr_wr.addr <= rd_q;
            gpr_wr.data <= rdata;
            op_ready    <= 1'b1;
            state       <= st_idle;
          end
        end
        st_store_req, st_store_wait: begin
          if (wreq_valid && wreq_ready) begin
            wreq_valid <= 1'b0;
            state      <= st_store_wait;
          end
          if (wres_hs) begin // nothing to write back
            wres_ready <= 1'b0;
            op_ready   <= 1'b1;
            state      <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // read request holds address and func until memory takes it
  assert property (@(posedge clk) disable iff (rstn)
    rreq_valid && !rreq_ready |=> rreq_valid && $stable(rreq));

  // decoder stays stalled for the whole memory op
  assert property (@(posedge clk) disable iff (rstn)
    state != st_idle |-> !op_ready);

  // back-to-back pulses only come from a newly accepted op
  assert property (@(posedge clk) disable iff (rstn)
    gpr_wr.en && !op_hs |=> !gpr_wr.en);

endmodule

// File: hdl/exu_top.sv
`timescale 1ns/1ps

module exu_top (
  input  logic              clk,
  input  logic              rstn,
  input  exu_pkg::exu_op_t  op_in,
  input  logic              op_valid,
  output logic              op_ready,
  output exu_pkg::mem_req_t rreq,
  output logic              rreq_valid,
  input  logic              rreq_ready,
  input  exu_pkg::word_t    rdata,
  input  logic              rres_valid,
  output logic              rres_ready,
  output exu_pkg::mem_req_t wreq,
  output logic              wreq_valid,
  input  logic              wreq_ready,
  input  logic              wres_valid,
  output logic              wres_ready,
  output exu_pkg::word_t    npc,
  output exu_pkg::gpr_wr_t  gpr_wr,
  output exu_pkg::csr_wr_t  csr_wr1,
  output exu_pkg::csr_wr_t  csr_wr2
);
  import exu_pkg::*;

  word_t   alu_val;
  gpr_wr_t gpr_next;   // candidate writes registered in ctrl
  csr_wr_t csr1_next;
  csr_wr_t csr2_next;

  exu_alu exu_alu_i (
    .alu_a       (op_in.alu_a),
    .alu_b       (op_in.alu_b),
    .alu_funct   (op_in.alu_funct),
    .alu_sub_sra (op_in.alu_sub_sra),
    .alu_val     (alu_val)
  );

  exu_branch exu_branch_i (
    .op      (op_in),
    .alu_val (alu_val),
    .npc     (npc)
  );

  exu_sys exu_sys_i (
    .op        (op_in),
    .alu_val   (alu_val),
    .gpr_next  (gpr_next),
    .csr1_next (csr1_next),
    .csr2_next (csr2_next)
  );

  exu_ctrl exu_ctrl_i (
    .clk        (clk),
    .rstn       (rstn),
    .op_in      (op_in),
    .op_valid   (op_valid),
    .op_ready   (op_ready),
    .gpr_next   (gpr_next),
    .csr1_next  (csr1_next),
    .csr2_next  (csr2_next),
    .rreq       (rreq),
    .rreq_valid (rreq_valid),
    .rreq_ready (rreq_ready),
    .rdata      (rdata),
    .rres_valid (rres_valid),
    .rres_ready (rres_ready),
    .wreq       (wreq),
    .wreq_valid (wreq_valid),
    .wreq_ready (wreq_ready),
    .wres_valid (wres_valid),
    .wres_ready (wres_ready),
    .gpr_wr     (gpr_wr),
    .csr_wr1    (csr_wr1),
    .csr_wr2    (csr_wr2)
  );

endmodule

// File: test/exu_tb.sv
`timescale 1ns/1ps

module exu_tb;
  import exu_pkg::*;

  localparam int vec_words = 19;  // 9 stimulus words then 10 expected words
  localparam int max_vec   = 64;

  logic     clk = 1'b0;
  logic     rstn;
  exu_op_t  op_in;
  logic     op_valid;
  logic     op_ready;
  mem_req_t rreq;
  logic     rreq_valid;
  logic     rreq_ready;
  word_t    rdata;
  logic     rres_valid;
  logic     rres_ready;
  mem_req_t wreq;
  logic     wreq_valid;
  logic     wreq_ready;
  logic     wres_valid;
  logic     wres_ready;
  word_t    npc;
  gpr_wr_t  gpr_wr;
  csr_wr_t  csr_wr1;
  csr_wr_t  csr_wr2;

  logic [31:0] vec_mem [0:vec_words*max_vec-1];
  logic [31:0] lfsr = 32'hd7a9;
  exu_op_t     decoy;  // parked at the decoder during memory ops
  int          test_errs;
  int          n_pass;
  int          n_fail;
  int          n_errs;
  int          cycles;
  int          cycle_limit = 64 * max_vec + 100;

  exu_top exu_top_i (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_delay(output int d);
    lfsr = lfsr_next(lfsr);
    d = int'(lfsr[0]);
    lfsr = lfsr_next(lfsr);
    d = 2 * d + int'(lfsr[0]);  // 0..3 cycles
  endtask

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] want);
    if (got !== want) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, want);
      test_errs++;
    end
  endtask

  task automatic next_drive_point;
    @(posedge clk);
    #1;
  endtask

  task automatic check_no_writes;
    check_eq("gpr_wr.en", 32'(gpr_wr.en), 32'd0);
    check_eq("csr_wr1.en", 32'(csr_wr1.en), 32'd0);
    check_eq("csr_wr2.en", 32'(csr_wr2.en), 32'd0);
  endtask

  task automatic check_stalled;
    check_eq("op_ready", 32'(op_ready), 32'd0);
    check_no_writes();
  endtask

  // expected write words hold the enable above the address
  task automatic check_writes(input int b);
    logic [31:0] gw;
    logic [31:0] c1;
    logic [31:0] c2;
    gw = vec_mem[b+10];
    c1 = vec_mem[b+12];
    c2 = vec_mem[b+14];
    check_eq("gpr_wr.en", 32'(gpr_wr.en), 32'(gw[8]));
    if (gw[8]) begin
      check_eq("gpr_wr.addr", 32'(gpr_wr.addr), 32'(gw[4:0]));
      check_eq("gpr_wr.data", gpr_wr.data, vec_mem[b+11]);
    end
    check_eq("csr_wr1.en", 32'(csr_wr1.en), 32'(c1[12]));
    if (c1[12]) begin
      check_eq("csr_wr1.addr", 32'(csr_wr1.addr), 32'(c1[11:0]));
      check_eq("csr_wr1.data", csr_wr1.data, vec_mem[b+13]);
    end
    check_eq("csr_wr2.en", 32'(csr_wr2.en), 32'(c2[12]));
    if (c2[12]) begin
      check_eq("csr_wr2.addr", 32'(csr_wr2.addr), 32'(c2[11:0]));
      check_eq("csr_wr2.data", csr_wr2.data, vec_mem[b+15]);
    end
  endtask

  task automatic run_mem(input int b, input logic is_load);
    int d;
    op_in    = decoy;  // must not be taken while memory is busy
    op_valid = 1'b1;
    rand_delay(d);
    repeat (d) begin
      @(negedge clk);
      check_stalled();
      next_drive_point();
    end
    rreq_ready = is_load;
    wreq_ready = !is_load;
    @(negedge clk);
    while (!(is_load ? rreq_valid : wreq_valid)) @(negedge clk);
    if (is_load) begin
      check_eq("rreq.addr", rreq.addr, vec_mem[b+16]);
      check_eq("rreq.func", 32'(rreq.func), vec_mem[b+18]);
    end else begin
      check_eq("wreq.addr", wreq.addr, vec_mem[b+16]);
      check_eq("wreq.data", wreq.data, vec_mem[b+17]);
      check_eq("wreq.func", 32'(wreq.func), vec_mem[b+18]);
    end
    check_stalled();
    next_drive_point();  // request taken
    rreq_ready = 1'b0;
    wreq_ready = 1'b0;
    rand_delay(d);
    repeat (d) begin
      @(negedge clk);
      check_stalled();
      next_drive_point();
    end
    rdata      = vec_mem[b+8];
    rres_valid = is_load;
    wres_valid = !is_load;
    @(negedge clk);
    while (!(is_load ? rres_ready : wres_ready)) @(negedge clk);
    next_drive_point();  // reply taken
    rres_valid = 1'b0;
    wres_valid = 1'b0;
    op_valid   = 1'b0;
    @(negedge clk);
    check_writes(b);
    check_eq("op_ready", 32'(op_ready), 32'd1);
    @(negedge clk);
    check_no_writes();
  endtask

  task automatic run_vector(input int idx);
    int          b;
    logic [31:0] ctrl;
    b    = idx * vec_words;
    ctrl = vec_mem[b];
    op_in.opcode      = opcode_e'(ctrl[28:24]);
    op_in.funct       = ctrl[22:20];
    op_in.rd          = ctrl[16:12];
    op_in.alu_funct   = alu_funct_e'(ctrl[10:8]);
    op_in.alu_sub_sra = ctrl[4];
    op_in.pc          = vec_mem[b+1];
    op_in.src1        = vec_mem[b+2];
    op_in.src2        = vec_mem[b+3];
    op_in.imm         = vec_mem[b+4];
    op_in.csr_val     = vec_mem[b+5];
    op_in.alu_a       = vec_mem[b+6];
    op_in.alu_b       = vec_mem[b+7];
    op_valid          = 1'b1;
    @(negedge clk);
    while (!op_ready) @(negedge clk);
    check_eq("npc", npc, vec_mem[b+9]);
    next_drive_point();  // op accepted
    if (op_in.opcode == op_load || op_in.opcode == op_store) begin
      run_mem(b, op_in.opcode == op_load);
    end else begin
      op_valid = 1'b0;
      @(negedge clk);
      check_writes(b);
      check_eq("op_ready", 32'(op_ready), 32'd1);
      @(negedge clk);
      check_no_writes();  // single-cycle pulse
    end
    next_drive_point();
  endtask

  task automatic report_test(input string label);
    if (test_errs == 0) begin
      $display("test %s: ok", label);
      n_pass++;
    end else begin
      $display("test %s: %0d mismatches", label, test_errs);
      n_fail++;
    end
    n_errs += test_errs;
    test_errs = 0;
  endtask

  initial begin
    int      n_vec;
    opcode_e kind;
    rstn         = 1'b1;
    op_in        = '0;
    op_valid     = 1'b0;
    rreq_ready   = 1'b0;
    rdata        = '0;
    rres_valid   = 1'b0;
    wreq_ready   = 1'b0;
    wres_valid   = 1'b0;
    decoy        = '0;
    decoy.opcode = op_calri;
    decoy.rd     = 5'd31;
    decoy.alu_a  = 32'h0bad;
    for (int i = 0; i < vec_words * max_vec; i++) vec_mem[i] = ~32'(i);
    $readmemh("test/exu_vectors.txt", vec_mem);
    n_vec = 0;
    while (n_vec < max_vec && vec_mem[n_vec * vec_words] !== ~32'(n_vec * vec_words))
      n_vec++;
    cycle_limit = 64 * n_vec + 100;

    repeat (16) @(posedge clk);
    #1;
    rstn = 1'b0;
    @(negedge clk);  // outputs still show the reset state
    check_eq("op_ready", 32'(op_ready), 32'd1);
    check_eq("rreq_valid", 32'(rreq_valid), 32'd0);
    check_eq("rres_ready", 32'(rres_ready), 32'd0);
    check_eq("wreq_valid", 32'(wreq_valid), 32'd0);
    check_eq("wres_ready", 32'(wres_ready), 32'd0);
    check_no_writes();
    report_test("reset");
    next_drive_point();

    for (int i = 0; i < n_vec; i++) begin
      kind = opcode_e'(vec_mem[i * vec_words][28:24]);
      run_vector(i);
      report_test($sformatf("%0d %s", i, kind.name()));
    end

    $display("%0d tests, %0d passed, %0d failed, %0d mismatches",
             n_pass + n_fail, n_pass, n_fail, n_errs);
    if (n_fail == 0 && n_vec > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      if (n_vec == 0) $display("no vectors were read from test/exu_vectors.txt");
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: test/exu_vectors.txt
// a: ctrl(opcode funct rd alu_funct sub_sra) pc src1 src2 imm csr_val alu_a alu_b rdata
// b: npc gpr(en,rd) gpr_data csr1(en,addr) csr1_data csr2(en,addr) csr2_data addr data func
04005000 00000100 00000010 00000000 00000023 00000000 00000010 00000023 00000000
00000104 00000105 00000033 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0c006010 00000104 00000005 00000009 00000000 00000000 00000005 00000009 00000000
00000108 00000106 fffffffc 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0c207200 00000108 fffffffd 00000002 00000000 00000000 fffffffd 00000002 00000000
0000010c 00000107 00000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
04508510 0000010c 80000010 00000000 00000004 00000000 80000010 00000004 00000000
00000110 00000108 f8000001 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0d009000 00000110 00000000 00000000 12345000 00000000 00000000 12345000 00000000
00000114 00000109 12345000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
18000010 00000114 00000055 00000055 00000010 00000000 00000055 00000055 00000000
00000124 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
18400200 00000124 00000005 00000003 fffffff0 00000000 00000005 00000003 00000000
00000128 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
1b001000 00000128 00000000 00000000 00000100 00000000 00000128 00000004 00000000
00000228 00000101 0000012c 00000000 00000000 00000000 00000000 00000000 00000000 00000000
19001000 00000228 00001003 00000000 00000004 00000000 00000228 00000004 00000000
00001006 00000101 0000022c 00000000 00000000 00000000 00000000 00000000 00000000 00000000
0020c000 00001008 00002000 00000000 00000010 00000000 00002000 00000010 cafef00d
0000100c 0000010c cafef00d 00000000 00000000 00000000 00000000 00002010 00000000 00000002
0040d000 0000100c 00002003 00000000 fffffffd 00000000 00002003 fffffffd 000000a5
00001010 0000010d 000000a5 00000000 00000000 00000000 00000000 00002000 00000000 00000004
08200000 00001010 00002000 deadbeef 00000020 00000000 00002000 00000020 00000000
00001014 00000000 00000000 00000000 00000000 00000000 00000000 00002020 deadbeef 00000002
1c10e600 00001014 00001111 00000000 00000340 0000abcd 00001111 00000000 00000000
00001018 0000010e 0000abcd 00001340 00001111 00000000 00000000 00000000 00000000 00000000
1c000000 00001018 00000000 00000000 00000000 00000200 00001018 00000000 00000000
00000200 00000000 00000000 00001341 00001018 00001342 0000000b 00000000 00000000 00000000
1c000000 00000200 00000000 00000000 00000302 0000101c 00000000 00000000 00000000
0000101c 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// File: flist.f
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_branch.sv
hdl/exu_sys.sv
hdl/exu_ctrl.sv
hdl/exu_top.sv
test/exu_tb.sv

// File: run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f flist.f --top-module exu_tb -o exu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/exu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
  exit 1
fi
exit 0
